// ==== bench/mcu_front_tests.svh ====
// every task starts and ends a short delay after a rising edge

// expected rows of a w x h frame in strip then macroblock order
task automatic build_model(input int w, input int h);
    mcu_pkg::mcu_row_t r;
    int                s;
    int                m;
    int                k;
    int                ln;
    int                c;
    int                px;
    int                py;
    for (s = 0; s < h / 16; s++) begin
        for (m = 0; m < w / 16; m++) begin
            for (k = 0; k < 6; k++) begin
                for (ln = 0; ln < 8; ln++) begin
                    r.kind = mcu_pkg::mcu_kind_e'(k);
                    r.row  = ln[2:0];
                    for (c = 0; c < 8; c++) begin
                        if (k < 4) begin
                            // odd blocks on the right and blocks 2 and 3 below
                            px = m * 16 + (k % 2) * 8 + c;
                            py = s * 16 + (k / 2) * 8 + ln;
                            r.smp[c] = shifted(frame[py * X_MAX + px].y);
                        end else begin
                            // chroma comes from the even-even pixel
                            px = 2 * (m * 8 + c);
                            py = 2 * (s * 8 + ln);
                            if (k == 4) begin
                                r.smp[c] = shifted(frame[py * X_MAX + px].u);
                            end else begin
                                r.smp[c] = shifted(frame[py * X_MAX + px].v);
                            end
                        end
                    end
                    exp_q.push_back(r);
                end
            end
        end
    end
endtask

// raster drive where a pixel counts once it is shown with hold low at an edge
task automatic send_frame(input int w, input int h);
    int   n;
    logic took;
    n           = 0;
    x_size_m1_i = XW'(w - 1);
    y_size_m1_i = YW'(h - 1);
    while (n < w * h) begin
        pix_i       = frame[(n / w) * X_MAX + (n % w)];
        pix_valid_i = 1'b1;
        @(negedge clk);
        took = !pix_hold_o;
        @(posedge clk);
        #DRIVE_DLY;
        if (took) begin
            n++;
        end
    end
    pix_valid_i = 1'b0;
endtask

// waits for all owed rows and then idles to catch extra ones
task automatic wait_drain();
    while (exp_q.size() != 0) begin
        @(posedge clk);
        #DRIVE_DLY;
    end
    @(negedge clk);
    hold_random = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    compare_bit({test_name, "_idle"}, 1'b0, row_valid_o);
    @(posedge clk);
    #DRIVE_DLY;
endtask

task automatic fill_random(input int w, input int h);
    logic [31:0] bits;
    for (int i = 0; i < w * h; i++) begin
        bits = rand_bits(24);
        frame[(i / w) * X_MAX + (i % w)] = bits[23:0];
    end
endtask

task automatic check_after_reset();
    test_name = "after_reset";
    @(negedge clk);
    compare_bit("after_reset_row_valid", 1'b0, row_valid_o);
    compare_bit("after_reset_pix_hold", 1'b0, pix_hold_o);
    @(posedge clk);
    #DRIVE_DLY;
endtask

// luma ramp of x + 16y with flat chroma
task automatic check_luma_ramp();
    test_name = "luma_ramp";
    for (int i = 0; i < 256; i++) begin
        frame[(i / 16) * X_MAX + (i % 16)] = {i[7:0], 8'h5a, 8'hc3};
    end
    build_model(16, 16);
    send_frame(16, 16);
    wait_drain();
endtask

// distinct chroma at every pixel so only even-even values can match
task automatic check_chroma_decimation();
    int x;
    int y;
    test_name = "chroma_decimation";
    for (int i = 0; i < 256; i++) begin
        x = i % 16;
        y = i / 16;
        frame[y * X_MAX + x] = {8'(x + y), 8'(x * 7 + y * 13), 8'(x * 11 + y * 5 + 3)};
    end
    build_model(16, 16);
    send_frame(16, 16);
    wait_drain();
endtask

task automatic check_random_frame();
    test_name = "random_32x48";
    fill_random(32, 48);
    build_model(32, 48);
    send_frame(32, 48);
    wait_drain();
endtask

// slow row drain must fill both strip slots and push back on pixels
task automatic check_backpressure();
    test_name = "backpressure";
    fill_random(32, 48);
    build_model(32, 48);
    @(negedge clk);
    seen_hold   = 1'b0;
    hold_random = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    send_frame(32, 48);
    wait_drain();
    compare_bit("backpressure_pix_hold_seen", 1'b1, seen_hold);
endtask

// second frame starts on the cycle after the first one ends
task automatic check_back_to_back();
    test_name = "back_to_back";
    fill_random(48, 32);
    build_model(48, 32);
    send_frame(48, 32);
    fill_random(48, 16);
    build_model(48, 16);
    send_frame(48, 16);
    wait_drain();
endtask

// ==== bench/mcu_front_tb.sv ====
`timescale 1ns/1ns

module mcu_front_tb;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;
    // small sensor keeps the runs short
    localparam int X_MAX      = 64;
    localparam int Y_MAX      = 64;
    localparam int XW         = $clog2(X_MAX);
    localparam int YW         = $clog2(Y_MAX);
    // pixels over all tests set the watchdog budget
    localparam int TOTAL_PIXELS = 256 + 256 + 1536 + 1536 + 1536 + 768;

    logic              clk;
    logic              resetn;
    mcu_pkg::pixel_t   pix_i;
    logic              pix_valid_i;
    logic              pix_hold_o;
    logic [XW-1:0]     x_size_m1_i;
    logic [YW-1:0]     y_size_m1_i;
    mcu_pkg::mcu_row_t row_o;
    logic              row_valid_o;
    logic              row_hold_i;

    // frame under test indexed by y * X_MAX + x
    mcu_pkg::pixel_t   frame [X_MAX * Y_MAX];
    // rows still owed by the DUT with the oldest first
    mcu_pkg::mcu_row_t exp_q [$];
    mcu_pkg::mcu_row_t exp_row;
    mcu_pkg::mcu_row_t held_row;
    logic              hold_pending;
    logic              seen_hold;
    logic              hold_random;
    logic [31:0]       lfsr;
    string             test_name;

    mcu_front_top #(
        .SENSOR_X_SIZE (X_MAX),
        .SENSOR_Y_SIZE (Y_MAX)
    ) DUT (
        .clk         (clk),
        .resetn      (resetn),
        .pix_i       (pix_i),
        .pix_valid_i (pix_valid_i),
        .pix_hold_o  (pix_hold_o),
        .x_size_m1_i (x_size_m1_i),
        .y_size_m1_i (y_size_m1_i),
        .row_o       (row_o),
        .row_valid_o (row_valid_o),
        .row_hold_i  (row_hold_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic compare_row(input string name, input mcu_pkg::mcu_row_t exp,
                               input mcu_pkg::mcu_row_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s expected %b actual %b", name, exp, act));
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // jpeg level shift from unsigned sample to signed around zero
    function automatic mcu_pkg::sample_s_t shifted(input logic [7:0] s);
        return mcu_pkg::sample_s_t'(s - mcu_pkg::JPEG_BIAS);
    endfunction

    // row back-pressure is random only while a test asks for it
    always @(posedge clk) begin
        #DRIVE_DLY;
        if (hold_random) begin
            row_hold_i = rand_bits(3) != 3'd0;
        end else begin
            row_hold_i = 1'b0;
        end
    end

    // outputs are stable at the falling edge
    // a row shown with hold low is taken at the next rising edge
    always @(negedge clk) begin
        if (resetn) begin
            if (hold_pending) begin
                compare_bit({test_name, "_hold_valid"}, 1'b1, row_valid_o);
                compare_row({test_name, "_hold_stable"}, held_row, row_o);
            end
            hold_pending = row_valid_o && row_hold_i;
            held_row     = row_o;
            if (pix_hold_o) begin
                seen_hold = 1'b1;
            end
            if (row_valid_o && !row_hold_i) begin
                if (exp_q.size() == 0) begin
                    abort_run("a row came out while no row was expected");
                end
                exp_row = exp_q.pop_front();
                compare_row(test_name, exp_row, row_o);
            end
        end
    end

    // ends a run that stalls
    initial begin
        #(TOTAL_PIXELS * 20 * CLK_PERIOD);
        abort_run("timeout, the DUT stopped producing rows");
    end

    `include "mcu_front_tests.svh"

    initial begin
        resetn       = 1'b0;
        pix_i        = '0;
        pix_valid_i  = 1'b0;
        row_hold_i   = 1'b0;
        x_size_m1_i  = XW'(15);
        y_size_m1_i  = YW'(15);
        hold_pending = 1'b0;
        seen_hold    = 1'b0;
        hold_random  = 1'b0;
        lfsr         = 32'h0b08_eafb;
        test_name    = "reset";
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        resetn = 1'b1;
        check_after_reset();
        check_luma_ramp();
        check_chroma_decimation();
        check_random_frame();
        check_backpressure();
        check_back_to_back();
        $display("No errors");
        $finish;
    end

endmodule

// ==== jpeg_mcu.f ====
+incdir+bench
logic/mcu_pkg.sv
logic/dp_ram_be.sv
logic/chroma_subsample_420.sv
logic/mcu_buffer.sv
logic/mcu_front_top.sv
bench/mcu_front_tb.sv

// ==== logic/chroma_subsample_420.sv ====
`timescale 1ns/1ns

module chroma_subsample_420 #(
    parameter int SENSOR_X_SIZE = 1280,
    parameter int SENSOR_Y_SIZE = 720
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  mcu_pkg::pixel_t                  pix_i,
    input  logic                             pix_valid_i,
    output logic                             pix_hold_o,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] x_size_m1_i,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] y_size_m1_i,
    output mcu_pkg::strip_wr_t               wr_o,
    output logic                             wr_valid_o,
    input  logic                             wr_hold_i
);

    localparam int XW = $clog2(SENSOR_X_SIZE);
    localparam int YW = $clog2(SENSOR_Y_SIZE);

    logic [XW-1:0]                x_cnt;
    logic [YW-1:0]                y_cnt;
    // v of the even pixel sent as cr with the odd pixel after it
    logic [mcu_pkg::SAMPLE_W-1:0] v_keep;
    logic                         take;

    // strip store full means we stall too
    assign pix_hold_o = wr_hold_i;
    assign take       = pix_valid_i && !wr_hold_i;

    // raster position wraps at line end and again at frame end
    always_ff @(posedge clk) begin
        if (!resetn) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (take) begin
            if (x_cnt == x_size_m1_i) begin
                x_cnt <= '0;
                if (y_cnt == y_size_m1_i) begin
                    y_cnt <= '0;
                end else begin
                    y_cnt <= y_cnt + 1'b1;
                end
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    // output valid freezes along with the payload while held
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_valid_o <= 1'b0;
        end else if (!wr_hold_i) begin
            wr_valid_o <= pix_valid_i;
        end
    end

    // payload register
    // every pixel carries luma
    // even lines carry cb on even x and the kept v as cr on odd x
    always_ff @(posedge clk) begin
        if (take) begin
            wr_o.luma         <= pix_i.y;
            wr_o.luma_valid   <= 1'b1;
            wr_o.chroma_valid <= !y_cnt[0];
            wr_o.cr_sel       <= x_cnt[0];
            wr_o.x            <= 11'(x_cnt);
            wr_o.line         <= 10'(y_cnt);
            if (x_cnt[0]) begin
                wr_o.chroma <= v_keep;
            end else begin
                wr_o.chroma <= pix_i.u;
                v_keep      <= pix_i.v;
            end
        end
    end

    // raster position stays inside the programmed frame
    assert property (@(posedge clk) disable iff (!resetn)
        (x_cnt <= x_size_m1_i) && (y_cnt <= y_size_m1_i));

endmodule

// ==== logic/dp_ram_be.sv ====
`timescale 1ns/1ns

module dp_ram_be #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 256
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] wa_i,
    input  logic [WIDTH-1:0]         wd_i,
    input  logic [7:0]               wbe_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] ra_i,
    input  logic                     re_i,
    output logic [WIDTH-1:0]         rd_o
);

    // eight equal byte lanes per word
    localparam int LANE_W = WIDTH / 8;

    logic [7:0][LANE_W-1:0] mem [DEPTH];

    // write port, each lane has its own enable
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int k = 0; k < 8; k++) begin
                if (wbe_i[k]) begin
                    mem[wa_i][k] <= wd_i[k*LANE_W +: LANE_W];
                end
            end
        end
    end

    // registered read port
    // data only moves on a read enable so the output can be stalled
    always_ff @(posedge clk) begin
        if (re_i) begin
            rd_o <= mem[ra_i];
        end
    end

endmodule

// ==== logic/mcu_buffer.sv ====
`timescale 1ns/1ns

module mcu_buffer #(
    parameter int SENSOR_X_SIZE = 1280,
    parameter int SENSOR_Y_SIZE = 720
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  mcu_pkg::strip_wr_t               wr_i,
    input  logic                             wr_valid_i,
    output logic                             wr_hold_o,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] x_size_m1_i,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] y_size_m1_i,
    output mcu_pkg::mcu_row_t                row_o,
    output logic                             row_valid_o,
    input  logic                             row_hold_i
);

    localparam int XW = $clog2(SENSOR_X_SIZE);
    localparam int YW = $clog2(SENSOR_Y_SIZE);
    localparam int SW = mcu_pkg::SAMPLE_W;

    // two strips of 16 luma lines, 8 samples per word
    localparam int Y_DEPTH = 2 * 16 * SENSOR_X_SIZE / 8;
    // two strips of 8 chroma lines, half width, cb and cr interleaved
    localparam int C_DEPTH = 2 * 2 * 8 * (SENSOR_X_SIZE / 2) / 8;

    // strip pointers, msb tells full from empty
    logic [1:0]      wptr;
    logic [1:0]      rptr;
    logic            full;
    logic            empty;

    logic            wr_take;
    logic            strip_last;
    logic [SW-1:0]   luma_b;
    logic [SW-1:0]   chroma_b;

    // read walk state
    logic [XW-5:0]          rd_blk;
    mcu_pkg::mcu_kind_e     rd_kind;
    logic [2:0]             rd_row;
    logic                   rd_issue;
    logic                   rd_last;
    logic                   luma_h;
    logic                   luma_v;
    logic                   rd_is_chroma;

    // what the issued read was, lines up with the ram output
    mcu_pkg::mcu_kind_e     kind_q;
    logic [2:0]             row_q;
    logic                   out_chroma;

    logic [8*SW-1:0]        rd_y;
    logic [8*SW-1:0]        rd_c;

    assign empty     = wptr == rptr;
    assign full      = (wptr[1] != rptr[1]) && (wptr[0] == rptr[0]);
    assign wr_hold_o = full;

    assign wr_take    = wr_valid_i && !full;
    // last pixel of a strip is the line end on line 15 or on the frame's last line
    assign strip_last = (wr_i.x[XW-1:0] == x_size_m1_i)
                     && ((wr_i.line[3:0] == 4'hf) || (wr_i.line[YW-1:0] == y_size_m1_i));

    // level shift on the way in
    assign luma_b   = wr_i.luma - mcu_pkg::JPEG_BIAS;
    assign chroma_b = wr_i.chroma - mcu_pkg::JPEG_BIAS;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr <= '0;
        end else if (wr_take && strip_last) begin
            wptr <= wptr + 1'b1;
        end
    end

    // luma word = x/8, line in strip, strip slot
    dp_ram_be #(
        .WIDTH (8 * SW),
        .DEPTH (Y_DEPTH)
    ) y_ram (
        .clk   (clk),
        .wa_i  ({wr_i.x[XW-1:3], wr_i.line[3:0], wptr[0]}),
        .wd_i  ({8{luma_b}}),
        .wbe_i (8'b1 << wr_i.x[2:0]),
        .we_i  (wr_take && wr_i.luma_valid),
        .ra_i  ({rd_blk, luma_h, luma_v, rd_row, rptr[0]}),
        .re_i  (rd_issue && !rd_is_chroma),
        .rd_o  (rd_y)
    );

    // chroma x is x/2, so the word is x/16 and the lane x/2 mod 8
    // lsb picks cb or cr
    dp_ram_be #(
        .WIDTH (8 * SW),
        .DEPTH (C_DEPTH)
    ) c_ram (
        .clk   (clk),
        .wa_i  ({wr_i.x[XW-1:4], wr_i.line[3:1], wptr[0], wr_i.cr_sel}),
        .wd_i  ({8{chroma_b}}),
        .wbe_i (8'b1 << wr_i.x[3:1]),
        .we_i  (wr_take && wr_i.chroma_valid),
        .ra_i  ({rd_blk, rd_row, rptr[0], rd_kind == mcu_pkg::kind_cr}),
        .re_i  (rd_issue && rd_is_chroma),
        .rd_o  (rd_c)
    );

    // y1 and y3 sit on the right half, y2 and y3 on the lower half
    assign luma_h       = (rd_kind == mcu_pkg::kind_y1) || (rd_kind == mcu_pkg::kind_y3);
    assign luma_v       = (rd_kind == mcu_pkg::kind_y2) || (rd_kind == mcu_pkg::kind_y3);
    assign rd_is_chroma = (rd_kind == mcu_pkg::kind_cb) || (rd_kind == mcu_pkg::kind_cr);

    assign rd_issue = !row_hold_i && !empty;
    assign rd_last  = (rd_row == 3'd7) && (rd_kind == mcu_pkg::kind_cr)
                   && (rd_blk == x_size_m1_i[XW-1:4]);

    // walk rows, then blocks, then macroblocks, then release the strip
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_row  <= '0;
            rd_kind <= mcu_pkg::kind_y0;
            rd_blk  <= '0;
            rptr    <= '0;
        end else if (rd_issue) begin
            rd_row <= rd_row + 1'b1;
            if (rd_row == 3'd7) begin
                case (rd_kind)
                    mcu_pkg::kind_y0: rd_kind <= mcu_pkg::kind_y1;
                    mcu_pkg::kind_y1: rd_kind <= mcu_pkg::kind_y2;
                    mcu_pkg::kind_y2: rd_kind <= mcu_pkg::kind_y3;
                    mcu_pkg::kind_y3: rd_kind <= mcu_pkg::kind_cb;
                    mcu_pkg::kind_cb: rd_kind <= mcu_pkg::kind_cr;
                    default:          rd_kind <= mcu_pkg::kind_y0;
                endcase
                if (rd_kind == mcu_pkg::kind_cr) begin
                    if (rd_last) begin
                        rd_blk <= '0;
                        rptr   <= rptr + 1'b1;
                    end else begin
                        rd_blk <= rd_blk + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_issue) begin
            kind_q <= rd_kind;
            row_q  <= rd_row;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            row_valid_o <= 1'b0;
        end else if (!row_hold_i) begin
            row_valid_o <= !empty;
        end
    end

    // pick the store that served the last issued read
    assign out_chroma = (kind_q == mcu_pkg::kind_cb) || (kind_q == mcu_pkg::kind_cr);

    always_comb begin
        row_o.kind = kind_q;
        row_o.row  = row_q;
        for (int i = 0; i < 8; i++) begin
            if (out_chroma) begin
                row_o.smp[i] = rd_c[i*SW +: SW];
            end else begin
                row_o.smp[i] = rd_y[i*SW +: SW];
            end
        end
    end

    // a refused write must come back unchanged from the subsampler
    assert property (@(posedge clk) disable iff (!resetn)
        wr_valid_i && wr_hold_o |=> wr_valid_i && $stable(wr_i));

    // only the six blocks of a 4:2:0 macroblock ever leave
    assert property (@(posedge clk) disable iff (!resetn)
        row_valid_o |-> row_o.kind inside {mcu_pkg::kind_y0, mcu_pkg::kind_y1,
                                           mcu_pkg::kind_y2, mcu_pkg::kind_y3,
                                           mcu_pkg::kind_cb, mcu_pkg::kind_cr});

    // stalled rows stay put until taken
    assert property (@(posedge clk) disable iff (!resetn)
        row_valid_o && row_hold_i |=> row_valid_o && $stable(row_o));

endmodule

// ==== logic/mcu_front_top.sv ====
`timescale 1ns/1ns

module mcu_front_top #(
    parameter int SENSOR_X_SIZE = 1280,
    parameter int SENSOR_Y_SIZE = 720
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  mcu_pkg::pixel_t                  pix_i,
    input  logic                             pix_valid_i,
    output logic                             pix_hold_o,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] x_size_m1_i,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] y_size_m1_i,
    output mcu_pkg::mcu_row_t                row_o,
    output logic                             row_valid_o,
    input  logic                             row_hold_i
);

    // subsampler to strip store
    mcu_pkg::strip_wr_t wr;
    logic               wr_valid;
    logic               wr_hold;

    chroma_subsample_420 #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) u_subsample (
        .clk         (clk),
        .resetn      (resetn),
        .pix_i       (pix_i),
        .pix_valid_i (pix_valid_i),
        .pix_hold_o  (pix_hold_o),
        .x_size_m1_i (x_size_m1_i),
        .y_size_m1_i (y_size_m1_i),
        .wr_o        (wr),
        .wr_valid_o  (wr_valid),
        .wr_hold_i   (wr_hold)
    );

    mcu_buffer #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) u_buffer (
        .clk         (clk),
        .resetn      (resetn),
        .wr_i        (wr),
        .wr_valid_i  (wr_valid),
        .wr_hold_o   (wr_hold),
        .x_size_m1_i (x_size_m1_i),
        .y_size_m1_i (y_size_m1_i),
        .row_o       (row_o),
        .row_valid_o (row_valid_o),
        .row_hold_i  (row_hold_i)
    );

endmodule

// ==== logic/mcu_pkg.sv ====
package mcu_pkg;

    // one image sample, luma or chroma
    localparam int SAMPLE_W = 8;

    // level shift that centers samples around zero for the dct
    localparam logic [SAMPLE_W-1:0] JPEG_BIAS = 8'd128;

    // a level-shifted sample as the dct expects it
    typedef logic signed [SAMPLE_W-1:0] sample_s_t;

    // full resolution input pixel
    typedef struct packed {
        logic [SAMPLE_W-1:0] y;
        logic [SAMPLE_W-1:0] u;
        logic [SAMPLE_W-1:0] v;
    } pixel_t;

    // 8x8 block order inside one 16x16 macroblock
    // y0 y1 on top, y2 y3 below, then cb and cr
    typedef enum logic [2:0] {
        kind_y0 = 3'd0,
        kind_y1 = 3'd1,
        kind_y2 = 3'd2,
        kind_y3 = 3'd3,
        kind_cb = 3'd4,
        kind_cr = 3'd5
    } mcu_kind_e;

    // one write into the strip store, carries its own raster position
    typedef struct packed {
        logic [SAMPLE_W-1:0] luma;
        logic [SAMPLE_W-1:0] chroma;
        logic                luma_valid;
        logic                chroma_valid;
        // set when chroma holds cr, clear for cb
        logic                cr_sel;
        logic [10:0]         x;
        logic [9:0]          line;
    } strip_wr_t;

    // one 8-sample block row, smp[0] is the leftmost column
    typedef struct packed {
        sample_s_t [7:0] smp;
        logic [2:0]      row;
        mcu_kind_e       kind;
    } mcu_row_t;

endpackage
